// File: verif/corr_input.txt
# S en re im : one sample cycle, re/im one bit per antenna (hex)
# W : switch banks | E slot re im : expected visibility (hex) | R count : random
# epoch 1, two full wraps with gaps
S 1 F 0
S 1 5 3
S 0 F F
S 1 A 6
S 1 C 9
S 1 2 8
S 1 7 E
S 1 3 C
S 1 0 F
S 0 6 6
S 1 9 9
S 1 6 0
S 1 B 4
S 1 4 B
W
E 0 0006 0003
E 1 0005 0004
E 2 0005 0002
E 3 0005 0002
E 4 0004 0003
E 5 0003 0002
# epoch 2, starts at slot 2 after the switch samples
S 1 1 2
S 1 F F
S 0 0 0
S 1 8 2
S 1 5 A
S 1 1 1
S 1 4 0
S 1 E 1
# switch requested mid pass at slot 3
W
E 0 0002 0002
E 1 0003 0001
E 2 0001 0003
E 3 0004 0002
E 4 0002 0002
E 5 0002 0002
# epoch 3, random samples with gaps
R 28
S 0 0 0
W

// File: tb.f
rtl/corr_pkg.sv
rtl/vis_correlator.sv
rtl/vis_bank_buffer.sv
rtl/vis_bus_reader.sv
rtl/corr_block_top.sv
verif/corr_block_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := corr_block_tb
FLIST     := tb.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)

// File: verif/corr_block_tb.sv
`timescale 1ns/100ps

module corr_block_tb;

   localparam int NP  = corr_pkg::NPAIRS;
   localparam int NA  = corr_pkg::NANT;
   localparam int TMO = 40;   // cycles allowed for any single wait

   logic                     clk_x;
   logic                     rst;
   logic                     en_i;
   logic                     sw_i;
   logic [NA-1:0]            re_i;
   logic [NA-1:0]            im_i;
   logic                     rd_req_i;
   logic [corr_pkg::SBITS:0] rd_adr_i;
   corr_pkg::acc_t           rd_dat_o;
   logic                     rd_ack_o;
   logic                     bank_o;

   corr_block_top u_dut (
      .clk_x    (clk_x),
      .rst      (rst),
      .en_i     (en_i),
      .re_i     (re_i),
      .im_i     (im_i),
      .sw_i     (sw_i),
      .rd_req_i (rd_req_i),
      .rd_adr_i (rd_adr_i),
      .rd_dat_o (rd_dat_o),
      .rd_ack_o (rd_ack_o),
      .bank_o   (bank_o)
   );

   // ------------------------------------------------------------------------
   // reference model state
   // ------------------------------------------------------------------------
   int             pa [NP] = '{0, 0, 0, 1, 1, 2};   // first antenna per slot
   int             pb [NP] = '{1, 2, 3, 2, 3, 3};   // second antenna per slot
   corr_pkg::acc_t m_re [2][NP];
   corr_pkg::acc_t m_im [2][NP];
   int             m_slot;
   logic           m_bank;
   logic           m_pend;
   logic           m_clr;
   logic           bank_d1;     // model bank one sample back
   logic           bank_d2;     // ... and two samples back
   logic [31:0]    lfsr = 32'h8063c058;
   logic           streaming;   // random samples while reading
   logic           rd_busy;     // handshake in progress

   initial begin
      clk_x = 1'b0;
      forever #5 clk_x = ~clk_x;
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic nb;
      nb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], nb};
      return nb;
   endfunction

   function automatic logic [7:0] rand_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[6:0], lfsr_bit()};   // one step per bit
      return v;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_acc(input string name, input corr_pkg::acc_t got,
                            input corr_pkg::acc_t exp);
      if (got !== exp) begin
         $display("Error %s got %h expected %h", name, got, exp);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_bank(input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error bank_o got %h expected %h", got, exp);
         $display("Simulation FAILED");
         $fatal(1);
      end
   endtask

   // one captured cycle through the arithmetic, slot and switch rules
   task automatic model_step(input logic en, input logic [NA-1:0] re,
                             input logic [NA-1:0] im, input logic sw);
      int   a;
      int   b;
      int   ar;
      int   ai;
      logic wrap;
      logic swap;
      if (en) begin
         a  = pa[m_slot];
         b  = pb[m_slot];
         ar = int'(re[a] == re[b]) + int'(im[a] == im[b]);
         ai = int'(im[a] == re[b]) + int'(re[a] != im[b]);
         if (m_clr) begin
            m_re[m_bank][m_slot] = corr_pkg::acc_t'(ar);
            m_im[m_bank][m_slot] = corr_pkg::acc_t'(ai);
         end else begin
            m_re[m_bank][m_slot] = m_re[m_bank][m_slot] + corr_pkg::acc_t'(ar);
            m_im[m_bank][m_slot] = m_im[m_bank][m_slot] + corr_pkg::acc_t'(ai);
         end
      end
      wrap = en && (m_slot == NP - 1);
      swap = wrap && (m_pend || sw);
      if (en)
         m_slot = wrap ? 0 : m_slot + 1;
      if (swap) begin
         m_pend = 1'b0;
         m_bank = ~m_bank;
         m_clr  = 1'b1;   // new epoch starts from zero
      end else begin
         if (sw)
            m_pend = 1'b1;
         if (wrap)
            m_clr = 1'b0;
      end
   endtask

   // ------------------------------------------------------------------------
   // cycle drivers
   // ------------------------------------------------------------------------
   task automatic tick(input logic en, input logic [NA-1:0] re,
                       input logic [NA-1:0] im, input logic sw);
      check_bank(bank_o, bank_d2);   // bank_o lags two samples
      if (!rd_busy && rd_ack_o)
         fail_run("acknowledge high with no read in progress");
      en_i = en;
      re_i = re;
      im_i = im;
      sw_i = sw;
      @(posedge clk_x);
      #1;
      bank_d2 = bank_d1;
      bank_d1 = m_bank;
      model_step(en, re, im, sw);
   endtask

   task automatic idle_tick();
      logic          en;
      logic [NA-1:0] re;
      logic [NA-1:0] im;
      if (streaming) begin
         en = (rand_bits(2) != 0);   // gap one cycle in four
         re = NA'(rand_bits(NA));
         im = NA'(rand_bits(NA));
         tick(en, re, im, 1'b0);
      end else begin
         tick(1'b0, '0, '0, 1'b0);
      end
   endtask

   task automatic run_random(input int count);
      int   got;
      logic en;
      got = 0;
      while (got < count) begin
         en = (rand_bits(2) != 0);
         tick(en, NA'(rand_bits(NA)), NA'(rand_bits(NA)), 1'b0);
         if (en)
            got++;
      end
   endtask

   task automatic do_switch();
      logic start;
      int   n;
      start = bank_o;
      tick(1'b1, '0, '0, 1'b1);   // request rides on the first zero sample
      n = 0;
      while (bank_o == start) begin
         tick(1'b1, '0, '0, 1'b0);
         n++;
         if (n > 4 * NP)
            fail_run("bank never switched after the request");
      end
      repeat (3) tick(1'b0, '0, '0, 1'b0);   // old bank writes drain
   endtask

   // ------------------------------------------------------------------------
   // four-phase read master
   // ------------------------------------------------------------------------
   task automatic read_half(input int slot, input logic sel,
                            output corr_pkg::acc_t val);
      int             n;
      corr_pkg::acc_t held;
      n = 0;
      while (rd_ack_o) begin
         idle_tick();
         n++;
         if (n > TMO)
            fail_run("acknowledge never dropped before the next request");
      end
      repeat (rand_bits(2)) idle_tick();
      rd_busy  = 1'b1;
      rd_adr_i = {corr_pkg::SBITS'(slot), sel};
      rd_req_i = 1'b1;
      n = 0;
      while (!rd_ack_o) begin
         idle_tick();
         n++;
         if (n > TMO)
            fail_run("no acknowledge from reader");
      end
      held = rd_dat_o;
      repeat (rand_bits(3)) begin   // slow master holds the request
         idle_tick();
         if (!rd_ack_o)
            fail_run("acknowledge dropped while the request was high");
         check_acc("rd_dat_o", rd_dat_o, held);
      end
      rd_req_i = 1'b0;
      n = 0;
      while (rd_ack_o) begin
         idle_tick();
         n++;
         if (n > TMO)
            fail_run("acknowledge stuck high after the request dropped");
      end
      rd_busy = 1'b0;
      val     = held;
   endtask

   // both halves against the file and the model, inactive bank
   task automatic check_slot(input int slot, input corr_pkg::acc_t f_re,
                             input corr_pkg::acc_t f_im);
      corr_pkg::acc_t v;
      read_half(slot, 1'b0, v);
      check_acc("rd_dat_o", v, f_re);
      check_acc("rd_dat_o", v, m_re[~m_bank][slot]);
      read_half(slot, 1'b1, v);
      check_acc("rd_dat_o", v, f_im);
      check_acc("rd_dat_o", v, m_im[~m_bank][slot]);
   endtask

   // repeated reads while the active bank keeps accumulating
   task automatic stream_readback();
      corr_pkg::acc_t v1;
      corr_pkg::acc_t v2;
      streaming = 1'b1;
      for (int s = 0; s < NP; s++) begin
         for (int h = 0; h < 2; h++) begin
            read_half(s, h[0], v1);
            read_half(s, h[0], v2);
            check_acc("rd_dat_o", v2, v1);
            check_acc("rd_dat_o", v1, h ? m_im[~m_bank][s] : m_re[~m_bank][s]);
         end
      end
      streaming = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      int          fd;
      int          cnt;
      string       line;
      string       rest;
      byte         c;
      logic [31:0] v0;
      logic [31:0] v1;
      logic [31:0] v2;
      rst       = 1'b1;
      en_i      = 1'b0;
      sw_i      = 1'b0;
      re_i      = '0;
      im_i      = '0;
      rd_req_i  = 1'b0;
      rd_adr_i  = '0;
      m_slot    = 0;
      m_bank    = 1'b0;
      m_pend    = 1'b0;
      m_clr     = 1'b1;
      bank_d1   = 1'b0;
      bank_d2   = 1'b0;
      streaming = 1'b0;
      rd_busy   = 1'b0;
      repeat (5) @(posedge clk_x);
      #1;
      rst = 1'b0;
      check_bank(bank_o, 1'b0);
      if (rd_ack_o)
         fail_run("acknowledge high right after reset");
      repeat (4) idle_tick();

      fd = $fopen("verif/corr_input.txt", "r");
      if (fd == 0)
         fail_run("cannot open verif/corr_input.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0)
            continue;
         c = line.getc(0);
         if (c == "#" || c == "\n" || c == "\r" || c == " ")
            continue;   // comment or blank
         rest = line.substr(1, line.len() - 1);
         case (c)
            "S": begin
               cnt = $sscanf(rest, "%h %h %h", v0, v1, v2);
               if (cnt != 3)
                  fail_run("malformed sample line in input file");
               tick(v0[0], v1[NA-1:0], v2[NA-1:0], 1'b0);
            end
            "W": do_switch();
            "E": begin
               cnt = $sscanf(rest, "%h %h %h", v0, v1, v2);
               if (cnt != 3)
                  fail_run("malformed expect line in input file");
               check_slot(int'(v0), corr_pkg::acc_t'(v1), corr_pkg::acc_t'(v2));
            end
            "R": begin
               cnt = $sscanf(rest, "%h", v0);
               if (cnt != 1)
                  fail_run("malformed random line in input file");
               run_random(int'(v0));
            end
            default: fail_run("unknown command in input file");
         endcase
      end
      $fclose(fd);

      stream_readback();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: rtl/corr_block_top.sv
`timescale 1ns/100ps

module corr_block_top (
   input  logic                      clk_x,
   input  logic                      rst,
   // antenna samples
   input  logic                      en_i,
   input  logic [corr_pkg::NANT-1:0] re_i,
   input  logic [corr_pkg::NANT-1:0] im_i,
   input  logic                      sw_i,
   // visibility readout
   input  logic                      rd_req_i,
   input  logic [corr_pkg::SBITS:0]  rd_adr_i,
   output corr_pkg::acc_t            rd_dat_o,
   output logic                      rd_ack_o,
   // status
   output logic                      bank_o
);

   // --------------------------------------------------------------------------
   // producer to buffer, buffer to consumer
   // --------------------------------------------------------------------------
   logic [corr_pkg::SBITS:0] acc_rd_adr;
   corr_pkg::vis_t           acc_rd_dat;
   logic                     acc_we;
   logic [corr_pkg::SBITS:0] acc_wr_adr;
   corr_pkg::vis_t           acc_wr_dat;
   logic [corr_pkg::SBITS:0] pub_rd_adr;
   corr_pkg::vis_t           pub_rd_dat;

   vis_correlator #(
      .NANT   (corr_pkg::NANT),
      .NPAIRS (corr_pkg::NPAIRS),
      .ACCUM  (corr_pkg::ACCUM),
      .PAIRS  (corr_pkg::DEFAULT_PAIRS)
   ) u_corr (
      .clk_x        (clk_x),
      .rst          (rst),
      .en_i         (en_i),
      .sw_i         (sw_i),
      .re_i         (re_i),
      .im_i         (im_i),
      .acc_rd_adr_o (acc_rd_adr),
      .acc_rd_dat_i (acc_rd_dat),
      .acc_we_o     (acc_we),
      .acc_wr_adr_o (acc_wr_adr),
      .acc_wr_dat_o (acc_wr_dat),
      .bank_o       (bank_o)
   );

   vis_bank_buffer #(
      .NPAIRS (corr_pkg::NPAIRS),
      .ACCUM  (corr_pkg::ACCUM)
   ) u_buf (
      .clk_x        (clk_x),
      .acc_rd_adr_i (acc_rd_adr),
      .acc_rd_dat_o (acc_rd_dat),
      .acc_we_i     (acc_we),
      .acc_wr_adr_i (acc_wr_adr),
      .acc_wr_dat_i (acc_wr_dat),
      .pub_rd_adr_i (pub_rd_adr),
      .pub_rd_dat_o (pub_rd_dat)
   );

   // reads the bank opposite bank_o
   vis_bus_reader #(
      .NPAIRS (corr_pkg::NPAIRS),
      .ACCUM  (corr_pkg::ACCUM)
   ) u_rdr (
      .clk_x        (clk_x),
      .rst          (rst),
      .rd_req_i     (rd_req_i),
      .rd_adr_i     (rd_adr_i),
      .bank_i       (bank_o),
      .rd_dat_o     (rd_dat_o),
      .rd_ack_o     (rd_ack_o),
      .pub_rd_adr_o (pub_rd_adr),
      .pub_rd_dat_i (pub_rd_dat)
   );

endmodule

// File: rtl/vis_bus_reader.sv
`timescale 1ns/100ps

module vis_bus_reader #(
   parameter int NPAIRS = corr_pkg::NPAIRS,
   parameter int ACCUM  = corr_pkg::ACCUM,
   localparam int SW = $clog2(NPAIRS),
   localparam int VW = 2 * ACCUM
) (
   input  logic             clk_x,
   input  logic             rst,
   input  logic             rd_req_i,
   input  logic [SW:0]      rd_adr_i,      // {slot, im select}
   input  logic             bank_i,        // active bank
   output logic [ACCUM-1:0] rd_dat_o,
   output logic             rd_ack_o,
   output logic [SW:0]      pub_rd_adr_o,
   input  logic [VW-1:0]    pub_rd_dat_i
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FETCH,     // address on the buffer
      ST_HOLD,      // data latched, ack up until req drops
      ST_RELEASE
   } state_t;

   state_t      state;
   logic        req_q;
   logic [SW:0] adr_q;

   // --------------------------------------------------------------------------
   // request and address capture
   // --------------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst)
         req_q <= 1'b0;
      else
         req_q <= rd_req_i;
   end

   // master keeps the address stable while req is up
   always_ff @(posedge clk_x) begin
      if (state == ST_IDLE)
         adr_q <= rd_adr_i;
   end

   assign pub_rd_adr_o = {~bank_i, adr_q[SW:1]};  // never the live bank

   // --------------------------------------------------------------------------
   // four-phase sequencing
   // --------------------------------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         state    <= ST_IDLE;
         rd_ack_o <= 1'b0;
      end else begin
         case (state)
            ST_IDLE:    if (req_q) state <= ST_FETCH;
            ST_FETCH:   state <= ST_HOLD;
            ST_HOLD: begin
               if (!rd_ack_o) begin
                  rd_ack_o <= 1'b1;        // data goes out with it
               end else if (!req_q) begin
                  rd_ack_o <= 1'b0;
                  state    <= ST_RELEASE;
               end
            end
            ST_RELEASE: state <= ST_IDLE;
            default:    state <= ST_IDLE;
         endcase
      end
   end

   // held output word, select 0 is the real half
   always_ff @(posedge clk_x) begin
      if (state == ST_HOLD && !rd_ack_o)
         rd_dat_o <= adr_q[0] ? pub_rd_dat_i[ACCUM-1:0] : pub_rd_dat_i[VW-1:ACCUM];
   end

endmodule

// File: rtl/vis_bank_buffer.sv
`timescale 1ns/100ps

module vis_bank_buffer #(
   parameter int NPAIRS = corr_pkg::NPAIRS,
   parameter int ACCUM  = corr_pkg::ACCUM,
   localparam int SW = $clog2(NPAIRS),
   localparam int VW = 2 * ACCUM
) (
   input  logic          clk_x,
   // correlator side, read-modify-write
   input  logic [SW:0]   acc_rd_adr_i,
   output logic [VW-1:0] acc_rd_dat_o,
   input  logic          acc_we_i,
   input  logic [SW:0]   acc_wr_adr_i,
   input  logic [VW-1:0] acc_wr_dat_i,
   // reader side, inactive bank only
   input  logic [SW:0]   pub_rd_adr_i,
   output logic [VW-1:0] pub_rd_dat_o
);

   // --------------------------------------------------------------------------
   // storage, bank 0 in the lower half
   // --------------------------------------------------------------------------
   logic [VW-1:0] mem [2*NPAIRS];

   // {bank, slot} to a word index
   function automatic int unsigned word_idx(input logic [SW:0] adr);
      int unsigned base;
      base = adr[SW] ? NPAIRS : 0;
      return base + int'(adr[SW-1:0]);
   endfunction

   // single write port
   always_ff @(posedge clk_x) begin
      if (acc_we_i)
         mem[word_idx(acc_wr_adr_i)] <= acc_wr_dat_i;
   end

   // --------------------------------------------------------------------------
   // read ports, both registered
   // --------------------------------------------------------------------------

   // old value for the accumulator, a write in the same cycle is not seen
   always_ff @(posedge clk_x) begin
      acc_rd_dat_o <= mem[word_idx(acc_rd_adr_i)];
   end

   always_ff @(posedge clk_x) begin
      pub_rd_dat_o <= mem[word_idx(pub_rd_adr_i)];  // frozen bank
   end

endmodule

// File: rtl/vis_correlator.sv
`timescale 1ns/100ps

module vis_correlator #(
   parameter int NANT   = corr_pkg::NANT,
   parameter int NPAIRS = corr_pkg::NPAIRS,
   parameter int ACCUM  = corr_pkg::ACCUM,
   parameter corr_pkg::pair_t [NPAIRS-1:0] PAIRS = corr_pkg::DEFAULT_PAIRS,
   localparam int SW = $clog2(NPAIRS),
   localparam int VW = 2 * ACCUM
) (
   input  logic            clk_x,
   input  logic            rst,
   input  logic            en_i,          // sample valid
   input  logic            sw_i,          // bank switch request
   input  logic [NANT-1:0] re_i,
   input  logic [NANT-1:0] im_i,
   output logic [SW:0]     acc_rd_adr_o,  // {bank, slot}
   input  logic [VW-1:0]   acc_rd_dat_i,
   output logic            acc_we_o,
   output logic [SW:0]     acc_wr_adr_o,
   output logic [VW-1:0]   acc_wr_dat_o,
   output logic            bank_o
);

   // --------------------------------------------------------------------------
   // stage 0: input registers
   // --------------------------------------------------------------------------
   logic            en_q;
   logic            sw_q;
   logic [NANT-1:0] re_q;
   logic [NANT-1:0] im_q;

   always_ff @(posedge clk_x) begin
      if (rst) begin
         en_q <= 1'b0;
         sw_q <= 1'b0;
      end else begin
         en_q <= en_i;
         sw_q <= sw_i;
      end
   end

   always_ff @(posedge clk_x) begin
      re_q <= re_i;
      im_q <= im_i;
   end

   // --------------------------------------------------------------------------
   // slot counter, bank swap and clear pass
   // --------------------------------------------------------------------------
   logic [SW-1:0] slot;
   logic          bank;   // active bank, internal copy
   logic          pend;   // switch seen, waiting for the wrap
   logic          clr;    // current pass overwrites instead of adding
   logic          last;
   logic          wrap;
   logic          swap;

   assign last = (slot == SW'(NPAIRS - 1));
   assign wrap = en_q && last;            // valid sample in the last slot
   assign swap = wrap && (pend || sw_q);  // late request still makes it

   always_ff @(posedge clk_x) begin
      if (rst) begin
         slot   <= '0;
         bank   <= 1'b0;
         pend   <= 1'b0;
         clr    <= 1'b1;   // first pass after reset starts from zero
         bank_o <= 1'b0;
      end else begin
         if (en_q)
            slot <= last ? '0 : slot + 1'b1;
         if (swap)
            pend <= 1'b0;
         else if (sw_q)
            pend <= 1'b1;
         // new epoch clears, a plain wrap ends the clear pass
         if (swap) begin
            bank <= ~bank;
            clr  <= 1'b1;
         end else if (wrap) begin
            clr  <= 1'b0;
         end
         bank_o <= bank;   // published one cycle behind the internal bank
      end
   end

   assign acc_rd_adr_o = {bank, slot};   // old value back next cycle

   // pair lookup and agreement counts
   corr_pkg::pair_t pr;
   logic            ra;
   logic            ia;
   logic            rb;
   logic            ib;
   logic [1:0]      add_re;
   logic [1:0]      add_im;

   assign pr = PAIRS[slot];
   assign ra = re_q[pr.ant_a];
   assign ia = im_q[pr.ant_a];
   assign rb = re_q[pr.ant_b];
   assign ib = im_q[pr.ant_b];

   assign add_re = {1'b0, ra ~^ rb} + {1'b0, ia ~^ ib};
   assign add_im = {1'b0, ia ~^ rb} + {1'b0, ra ^ ib};  // conj product sign

   // --------------------------------------------------------------------------
   // stage 1: counts travel with slot, bank and clear flag
   // --------------------------------------------------------------------------
   logic          vld1;
   logic [SW-1:0] slot1;
   logic          bank1;
   logic          clr1;
   logic [1:0]    add_re1;
   logic [1:0]    add_im1;

   always_ff @(posedge clk_x) begin
      if (rst)
         vld1 <= 1'b0;
      else
         vld1 <= en_q;
   end

   always_ff @(posedge clk_x) begin
      slot1   <= slot;
      bank1   <= bank;    // bank the sample belonged to
      clr1    <= clr;
      add_re1 <= add_re;
      add_im1 <= add_im;
   end

   // --------------------------------------------------------------------------
   // stage 2: add to old value, register the write
   // --------------------------------------------------------------------------
   logic [ACCUM-1:0] old_re;
   logic [ACCUM-1:0] old_im;
   logic [ACCUM-1:0] new_re;
   logic [ACCUM-1:0] new_im;

   assign old_re = acc_rd_dat_i[VW-1:ACCUM];
   assign old_im = acc_rd_dat_i[ACCUM-1:0];
   assign new_re = clr1 ? ACCUM'(add_re1) : old_re + ACCUM'(add_re1);  // wraps
   assign new_im = clr1 ? ACCUM'(add_im1) : old_im + ACCUM'(add_im1);

   always_ff @(posedge clk_x) begin
      if (rst)
         acc_we_o <= 1'b0;
      else
         acc_we_o <= vld1;
   end

   always_ff @(posedge clk_x) begin
      acc_wr_adr_o <= {bank1, slot1};
      acc_wr_dat_o <= {new_re, new_im};
   end

endmodule

// File: rtl/corr_pkg.sv
package corr_pkg;

   // --------------------------------------------------------------------------
   // array sizes
   // --------------------------------------------------------------------------
   localparam int NANT   = 4;   // antennas, one bit re + one bit im each
   localparam int NPAIRS = 6;   // pairs == time slots, keep >= 3 for the rmw
   localparam int ACCUM  = 16;  // bits per accumulator
   localparam int SBITS  = 3;   // slot index width

   // one entry of the pair table
   typedef struct packed {
      logic [1:0] ant_a;        // first antenna
      logic [1:0] ant_b;        // second antenna
   } pair_t;

   // all six pairs of four antennas, entry 0 is (0,1)
   localparam pair_t [NPAIRS-1:0] DEFAULT_PAIRS = {
      pair_t'{ant_a: 2'd2, ant_b: 2'd3},
      pair_t'{ant_a: 2'd1, ant_b: 2'd3},
      pair_t'{ant_a: 2'd1, ant_b: 2'd2},
      pair_t'{ant_a: 2'd0, ant_b: 2'd3},
      pair_t'{ant_a: 2'd0, ant_b: 2'd2},
      pair_t'{ant_a: 2'd0, ant_b: 2'd1}
   };

   // --------------------------------------------------------------------------
   // stored visibility word
   // --------------------------------------------------------------------------
   typedef logic [ACCUM-1:0] acc_t;

   // real half sits above the imaginary half
   typedef struct packed {
      acc_t re;
      acc_t im;
   } vis_t;

endpackage
